//--- design/core_params.svh
//////////////////////////////////////////////////
// core parameters
// word and address widths, and the opcode and
// function field encodings of the integer subset.
//////////////////////////////////////////////////
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define DATA_WIDTH     32
`define PC_WIDTH       16
`define REG_ADDR_WIDTH 5

`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ORI   6'h0d
`define OP_LW    6'h23
`define OP_SW    6'h2b

`define FN_SLL   6'h00
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_XOR   6'h26
`define FN_SLT   6'h2a

`endif

//--- design/corePkg.sv
//////////////////////////////////////////////////
// core package
// instruction word views, ALU operations and the
// bundles carried by the pipeline registers.
//////////////////////////////////////////////////
`default_nettype none
`include "core_params.svh"

package corePkg;

    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } rTypeFields;

    // J also uses this view, imm holds the word target.
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                imm;
    } iTypeFields;

    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instrWord;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll
    } aluOp;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrcImm;
        logic branch;
        logic branchNe;
        logic jump;
        aluOp aluSel;
    } ctrlBundle;

    typedef struct packed {
        logic                       valid;
        ctrlBundle                  ctrl;
        logic [`REG_ADDR_WIDTH-1:0] rsAddr;
        logic [`REG_ADDR_WIDTH-1:0] rtAddr;
        logic [`REG_ADDR_WIDTH-1:0] dstAddr;
        logic [`DATA_WIDTH-1:0]     rsData;
        logic [`DATA_WIDTH-1:0]     rtData;
        logic [`DATA_WIDTH-1:0]     imm;
        logic [4:0]                 shamt;
        logic [`PC_WIDTH-1:0]       pc;
    } decodeBundle;

    typedef struct packed {
        logic                       valid;
        logic                       regWrite;
        logic                       memRead;
        logic                       memWrite;
        logic                       memToReg;
        logic [`REG_ADDR_WIDTH-1:0] dstAddr;
        logic [`DATA_WIDTH-1:0]     result;
        logic [`DATA_WIDTH-1:0]     storeData;
    } memBundle;

    typedef struct packed {
        logic                       regWrite;
        logic                       memToReg;
        logic [`REG_ADDR_WIDTH-1:0] dstAddr;
        logic [`DATA_WIDTH-1:0]     result;
    } wbBundle;

endpackage

`default_nettype wire

//--- design/fetchStage.sv
//////////////////////////////////////////////////
// fetch stage
// program counter and the F-to-D instruction
// register; holds on stall, jumps on redirect.
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module fetchStage (
    input  logic                 Clock,
    input  logic                 nReset,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [`PC_WIDTH-1:0] redirectPc,
    input  corePkg::instrWord    instrIn,
    output logic [`PC_WIDTH-1:0] pc,
    output corePkg::instrWord    fetchInstr,
    output logic [`PC_WIDTH-1:0] fetchPc,
    output logic                 fetchValid
);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else if (redirect) begin
            pc         <= redirectPc;
            fetchValid <= 1'b0;         // word fetched on the wrong path.
        end else if (!stall) begin
            pc         <= pc + `PC_WIDTH'd4;
            fetchValid <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (!stall) begin
            fetchInstr <= instrIn;
            fetchPc    <= pc;
        end
    end

endmodule

`default_nettype wire

//--- design/registerFile.sv
//////////////////////////////////////////////////
// register file
// 32 words, two read ports and a debug port, with
// the W write passed straight through to readers.
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module registerFile (
    input  logic                       Clock,
    input  logic                       nReset,
    input  logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    input  logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    input  logic                       wbWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] wbAddr,
    input  logic [`DATA_WIDTH-1:0]     wbData,
    input  logic [`REG_ADDR_WIDTH-1:0] debugAddr,
    output logic [`DATA_WIDTH-1:0]     rsData,
    output logic [`DATA_WIDTH-1:0]     rtData,
    output logic [`DATA_WIDTH-1:0]     debugData
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        if (addr == '0)
            return '0;
        if (wbWrite && wbAddr == addr)
            return wbData;              // value being written this cycle.
        return regs[addr];
    endfunction

    always_comb begin
        rsData    = readPort(rsAddr);
        rtData    = readPort(rtAddr);
        debugData = readPort(debugAddr);
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

endmodule

`default_nettype wire

//--- design/decodeControl.sv
//////////////////////////////////////////////////
// decode and control
// decodes the D instruction, detects load-use
// hazards and drives the D-to-E pipeline register.
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module decodeControl (
    input  logic                       Clock,
    input  logic                       nReset,
    input  corePkg::instrWord          fetchInstr,
    input  logic [`PC_WIDTH-1:0]       fetchPc,
    input  logic                       fetchValid,
    input  logic [`DATA_WIDTH-1:0]     rsData,
    input  logic [`DATA_WIDTH-1:0]     rtData,
    input  logic                       redirect,
    output logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    output logic [`REG_ADDR_WIDTH-1:0] rtAddr,
    output logic                       stall,
    output corePkg::decodeBundle       decoded
);

    corePkg::ctrlBundle         ctrl;
    corePkg::decodeBundle       nextDecoded;
    logic [5:0]                 opcode;
    logic [15:0]                imm;
    logic [`REG_ADDR_WIDTH-1:0] dstAddr;
    logic                       rsUsed;
    logic                       rtUsed;
    logic                       loadInE;

    assign opcode = fetchInstr.iType.opcode;
    assign imm    = fetchInstr.iType.imm;
    assign rsAddr = fetchInstr.iType.rs;
    assign rtAddr = fetchInstr.iType.rt;
    assign rsUsed = opcode != `OP_J;

    always_comb begin
        ctrl    = '0;
        dstAddr = fetchInstr.iType.rt;
        rtUsed  = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                dstAddr       = fetchInstr.rType.rd;
                rtUsed        = 1'b1;
                ctrl.regWrite = 1'b1;
                case (fetchInstr.rType.funct)
                    `FN_ADD: ctrl.aluSel = corePkg::aluAdd;
                    `FN_SUB: ctrl.aluSel = corePkg::aluSub;
                    `FN_AND: ctrl.aluSel = corePkg::aluAnd;
                    `FN_OR:  ctrl.aluSel = corePkg::aluOr;
                    `FN_XOR: ctrl.aluSel = corePkg::aluXor;
                    `FN_SLT: ctrl.aluSel = corePkg::aluSlt;
                    `FN_SLL: ctrl.aluSel = corePkg::aluSll;
                    default: ctrl.regWrite = 1'b0;     // unknown function runs as a nop.
                endcase
            end
            `OP_ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_ORI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSel    = corePkg::aluOr;
            end
            `OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                rtUsed         = 1'b1;
            end
            `OP_BEQ: begin
                ctrl.branch = 1'b1;
                rtUsed      = 1'b1;
            end
            `OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                rtUsed        = 1'b1;
            end
            `OP_J:   ctrl.jump = 1'b1;
            default: ;
        endcase
        // writes to register zero never leave decode.
        if (dstAddr == '0)
            ctrl.regWrite = 1'b0;
    end

    // a load in E whose result the D instruction needs.
    assign loadInE = decoded.valid && decoded.ctrl.memRead && decoded.dstAddr != '0;
    assign stall   = fetchValid && loadInE
                     && ((rsUsed && decoded.dstAddr == rsAddr)
                         || (rtUsed && decoded.dstAddr == rtAddr));

    always_comb begin
        nextDecoded.valid   = fetchValid;
        nextDecoded.ctrl    = ctrl;
        nextDecoded.rsAddr  = rsAddr;
        nextDecoded.rtAddr  = rtAddr;
        nextDecoded.dstAddr = dstAddr;
        nextDecoded.rsData  = rsData;
        nextDecoded.rtData  = rtData;
        nextDecoded.shamt   = fetchInstr.rType.shamt;
        nextDecoded.pc      = fetchPc;
        if (opcode == `OP_ORI)
            nextDecoded.imm = {{(`DATA_WIDTH-16){1'b0}}, imm};
        else
            nextDecoded.imm = {{(`DATA_WIDTH-16){imm[15]}}, imm};
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            decoded <= '0;
        else if (redirect || stall)
            decoded <= '0;              // bubble into E.
        else
            decoded <= nextDecoded;
    end

endmodule

`default_nettype wire

//--- design/executeUnit.sv
//////////////////////////////////////////////////
// execute unit
// operand forwarding, ALU, branch resolution and
// the E-to-M pipeline register.
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module executeUnit (
    input  logic                       Clock,
    input  logic                       nReset,
    input  corePkg::decodeBundle       decoded,
    input  logic                       wbWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] wbAddr,
    input  logic [`DATA_WIDTH-1:0]     wbData,
    output logic                       redirect,
    output logic [`PC_WIDTH-1:0]       redirectPc,
    output corePkg::memBundle          memStage
);

    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] rtFwd;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`PC_WIDTH-1:0]   offset;
    logic                   taken;

    // the M result is younger than W, so it wins.
    function automatic logic [`DATA_WIDTH-1:0] forwardOperand(
        input logic [`REG_ADDR_WIDTH-1:0] addr,
        input logic [`DATA_WIDTH-1:0]     regValue
    );
        if (memStage.valid && memStage.regWrite && memStage.dstAddr == addr)
            return memStage.result;
        if (wbWrite && wbAddr == addr)
            return wbData;
        return regValue;
    endfunction

    always_comb begin
        opA   = forwardOperand(decoded.rsAddr, decoded.rsData);
        rtFwd = forwardOperand(decoded.rtAddr, decoded.rtData);
        opB   = decoded.ctrl.aluSrcImm ? decoded.imm : rtFwd;
        case (decoded.ctrl.aluSel)
            corePkg::aluSub: aluResult = opA - opB;
            corePkg::aluAnd: aluResult = opA & opB;
            corePkg::aluOr:  aluResult = opA | opB;
            corePkg::aluXor: aluResult = opA ^ opB;
            corePkg::aluSlt: aluResult = `DATA_WIDTH'($signed(opA) < $signed(opB));
            corePkg::aluSll: aluResult = opB << decoded.shamt;
            default:         aluResult = opA + opB;
        endcase
    end

    assign offset = decoded.imm[`PC_WIDTH-1:0] << 2;
    assign taken  = decoded.ctrl.jump
                    || (decoded.ctrl.branch && ((opA == rtFwd) != decoded.ctrl.branchNe));

    assign redirect   = decoded.valid && taken;
    assign redirectPc = decoded.ctrl.jump ? offset : decoded.pc + `PC_WIDTH'd4 + offset;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            memStage <= '0;
        end else begin
            memStage.valid     <= decoded.valid;
            memStage.regWrite  <= decoded.ctrl.regWrite;
            memStage.memRead   <= decoded.ctrl.memRead;
            memStage.memWrite  <= decoded.ctrl.memWrite;
            memStage.memToReg  <= decoded.ctrl.memToReg;
            memStage.dstAddr   <= decoded.dstAddr;
            memStage.result    <= aluResult;
            memStage.storeData <= rtFwd;
        end
    end

endmodule

`default_nettype wire

//--- design/memoryAccess.sv
//////////////////////////////////////////////////
// memory access
// drives the data memory port in M, then picks the
// load data or ALU result for the W write.
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module memoryAccess (
    input  logic                       Clock,
    input  logic                       nReset,
    input  corePkg::memBundle          memStage,
    input  logic [`DATA_WIDTH-1:0]     MemData,
    output logic [`PC_WIDTH-1:0]       MemAddr,
    output logic [`DATA_WIDTH-1:0]     WriteData,
    output logic                       MemWrite,
    output logic                       MemRead,
    output logic                       wbWrite,
    output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
    output logic [`DATA_WIDTH-1:0]     wbData
);

    corePkg::wbBundle wb;

    assign MemAddr   = memStage.result[`PC_WIDTH-1:0];
    assign WriteData = memStage.storeData;
    assign MemWrite  = memStage.valid && memStage.memWrite;
    assign MemRead   = memStage.valid && memStage.memRead;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            wb <= '0;
        end else begin
            wb.regWrite <= memStage.valid && memStage.regWrite;
            wb.memToReg <= memStage.memToReg;
            wb.dstAddr  <= memStage.dstAddr;
            wb.result   <= memStage.result;
        end
    end

    // registered-read memory returns the load word during W.
    assign wbWrite = wb.regWrite;
    assign wbAddr  = wb.dstAddr;
    assign wbData  = wb.memToReg ? MemData : wb.result;

endmodule

`default_nettype wire

//--- design/pipelineCore.sv
//////////////////////////////////////////////////
// pipeline core
// five-stage in-order integer core, F D E M W,
// with forwarding and a load-use stall.
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module pipelineCore (
    input  logic                       Clock,
    input  logic                       nReset,
    input  logic [`DATA_WIDTH-1:0]     InstrMem,
    input  logic [`DATA_WIDTH-1:0]     MemData,
    input  logic [`REG_ADDR_WIDTH-1:0] RegAddr,
    output logic [`PC_WIDTH-1:0]       InstrAddr,
    output logic [`PC_WIDTH-1:0]       MemAddr,
    output logic [`DATA_WIDTH-1:0]     WriteData,
    output logic                       MemWrite,
    output logic                       MemRead,
    output logic [`DATA_WIDTH-1:0]     RegData,
    output logic                       nStall
);

    logic                       stall;
    logic                       redirect;
    logic [`PC_WIDTH-1:0]       redirectPc;
    corePkg::instrWord          fetchInstr;
    logic [`PC_WIDTH-1:0]       fetchPc;
    logic                       fetchValid;
    logic [`REG_ADDR_WIDTH-1:0] rsAddr;
    logic [`REG_ADDR_WIDTH-1:0] rtAddr;
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rtData;
    corePkg::decodeBundle       decoded;
    corePkg::memBundle          memStage;
    logic                       wbWrite;
    logic [`REG_ADDR_WIDTH-1:0] wbAddr;
    logic [`DATA_WIDTH-1:0]     wbData;

    assign nStall = !stall;

    fetchStage fetch_i (
        .Clock      (Clock),
        .nReset     (nReset),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instrIn    (InstrMem),
        .pc         (InstrAddr),
        .fetchInstr (fetchInstr),
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid)
    );

    registerFile regs_i (
        .Clock     (Clock),
        .nReset    (nReset),
        .rsAddr    (rsAddr),
        .rtAddr    (rtAddr),
        .wbWrite   (wbWrite),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .debugAddr (RegAddr),
        .rsData    (rsData),
        .rtData    (rtData),
        .debugData (RegData)
    );

    decodeControl decode_i (
        .Clock      (Clock),
        .nReset     (nReset),
        .fetchInstr (fetchInstr),
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid),
        .rsData     (rsData),
        .rtData     (rtData),
        .redirect   (redirect),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .stall      (stall),
        .decoded    (decoded)
    );

    executeUnit execute_i (
        .Clock      (Clock),
        .nReset     (nReset),
        .decoded    (decoded),
        .wbWrite    (wbWrite),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .memStage   (memStage)
    );

    memoryAccess memory_i (
        .Clock     (Clock),
        .nReset    (nReset),
        .memStage  (memStage),
        .MemData   (MemData),
        .MemAddr   (MemAddr),
        .WriteData (WriteData),
        .MemWrite  (MemWrite),
        .MemRead   (MemRead),
        .wbWrite   (wbWrite),
        .wbAddr    (wbAddr),
        .wbData    (wbData)
    );

endmodule

`default_nettype wire

//--- test/isaModel.svh
//////////////////////////////////////////////////
// instruction-level model
// runs the program in order, one instruction at a
// time, and keeps the final registers and every
// store in program order.
//////////////////////////////////////////////////
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [`DATA_WIDTH-1:0] refRegs [32];
logic [`DATA_WIDTH-1:0] refMem [64];
logic [`PC_WIDTH-1:0]   refStoreAddr [$];
logic [`DATA_WIDTH-1:0] refStoreData [$];

function automatic logic [`DATA_WIDTH-1:0] aluValue(
    input logic [5:0]             funct,
    input logic [`DATA_WIDTH-1:0] a,
    input logic [`DATA_WIDTH-1:0] b,
    input logic [4:0]             shamt
);
    case (funct)
        `FN_SUB: return a - b;
        `FN_AND: return a & b;
        `FN_OR:  return a | b;
        `FN_XOR: return a ^ b;
        `FN_SLT: return ($signed(a) < $signed(b)) ? `DATA_WIDTH'(1) : '0;
        `FN_SLL: return b << shamt;
        default: return a + b;
    endcase
endfunction

function automatic void writeReg(
    input logic [`REG_ADDR_WIDTH-1:0] addr,
    input logic [`DATA_WIDTH-1:0]     value
);
    if (addr != '0)
        refRegs[addr] = value;          // register zero stays 0.
endfunction

task automatic runModel(input int len);
    corePkg::instrWord      ins;
    logic [`PC_WIDTH-1:0]   pc;
    logic [`PC_WIDTH-1:0]   nextPc;
    logic [`PC_WIDTH-1:0]   offset;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] ea;
    logic                   done;
    int                     steps;
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    refStoreAddr.delete();
    refStoreData.delete();
    for (int i = 0; i < 32; i++)
        refRegs[5'(i)] = '0;
    for (int i = 0; i < 64; i++)
        refMem[6'(i)] = fillWord(i);
    // forward-only control flow, so len steps always reach the end.
    while (!done && steps < 4 * len) begin
        ins    = rom[pc[9:2]];
        a      = refRegs[ins.iType.rs];
        b      = refRegs[ins.iType.rt];
        ea     = a + {{16{ins.iType.imm[15]}}, ins.iType.imm};
        offset = {ins.iType.imm[13:0], 2'b00};
        nextPc = pc + 16'd4;
        case (ins.iType.opcode)
            `OP_RTYPE: writeReg(ins.rType.rd, aluValue(ins.rType.funct, a, b, ins.rType.shamt));
            `OP_ADDI:  writeReg(ins.iType.rt, ea);
            `OP_ORI:   writeReg(ins.iType.rt, a | {16'd0, ins.iType.imm});
            `OP_LW:    writeReg(ins.iType.rt, refMem[ea[7:2]]);
            `OP_SW: begin
                refMem[ea[7:2]] = b;
                refStoreAddr.push_back(ea[`PC_WIDTH-1:0]);
                refStoreData.push_back(b);
            end
            `OP_BEQ: if (a == b) nextPc = pc + 16'd4 + offset;
            `OP_BNE: if (a != b) nextPc = pc + 16'd4 + offset;
            `OP_J: begin
                done   = offset == pc;  // a jump to itself ends the program.
                nextPc = offset;
            end
            default: ;
        endcase
        pc = nextPc;
        steps++;
    end
endtask

`endif

//--- test/coreTb.sv
//////////////////////////////////////////////////
// core testbench
// runs random programs on the pipelined core and
// checks registers and stores against an
// instruction-level model.
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "core_params.svh"

module coreTb;

    localparam int resetCycles = 10;
    localparam int aluLength   = 40;
    localparam int memLength   = 40;
    localparam int ctrlLength  = 48;
    localparam int mixedLength = 96;
    localparam int cycleLimit  = 8 * (aluLength + memLength + ctrlLength + mixedLength)
                                 + 4 * resetCycles;

    logic                       Clock;
    logic                       nReset;
    logic [`DATA_WIDTH-1:0]     InstrMem;
    logic [`DATA_WIDTH-1:0]     MemData;
    logic [`REG_ADDR_WIDTH-1:0] RegAddr;
    logic [`PC_WIDTH-1:0]       InstrAddr;
    logic [`PC_WIDTH-1:0]       MemAddr;
    logic [`DATA_WIDTH-1:0]     WriteData;
    logic                       MemWrite;
    logic                       MemRead;
    logic [`DATA_WIDTH-1:0]     RegData;
    logic                       nStall;

    logic [`DATA_WIDTH-1:0]     rom [256];
    logic [`DATA_WIDTH-1:0]     dataMem [64];
    logic [`PC_WIDTH-1:0]       endPc;
    logic [31:0]                lcgState;
    logic [`REG_ADDR_WIDTH-1:0] lastDst;
    logic                       useLoad;
    int                         storesSeen = 0;
    int                         storeBase = 0;
    int                         stallsSeen = 0;
    int                         cycles = 0;
    int                         testCount = 0;
    int                         checkCount = 0;
    int                         errorCount = 0;

    pipelineCore dut_i (
        .Clock     (Clock),
        .nReset    (nReset),
        .InstrMem  (InstrMem),
        .MemData   (MemData),
        .RegAddr   (RegAddr),
        .InstrAddr (InstrAddr),
        .MemAddr   (MemAddr),
        .WriteData (WriteData),
        .MemWrite  (MemWrite),
        .MemRead   (MemRead),
        .RegData   (RegData),
        .nStall    (nStall)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    function automatic logic [31:0] randomWord();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randomBelow(input int n);
        return int'((randomWord() >> 8) % 32'(n));
    endfunction

    function automatic logic [`REG_ADDR_WIDTH-1:0] randomReg();
        return 5'(1 + randomBelow(7));  // r1 to r7 keeps dependencies dense.
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] fillWord(input int index);
        return 32'(index) * 32'h9e37_79b9 + 32'h1357_9bdf;
    endfunction

    `include "isaModel.svh"

    // picks 0 to 6 are R-type, then ADDI, ORI, LW, SW, BEQ, BNE and J.
    function automatic logic [31:0] genInstr(input int kind, input int idx, input int len);
        int                         pick;
        int                         reach;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [15:0]                imm;
        logic [5:0]                 funct;
        rs    = (randomBelow(2) == 1) ? lastDst : randomReg();
        rt    = randomReg();
        rd    = randomReg();
        imm   = 16'(randomWord() >> 16);
        reach = (len - 2 - idx < 3) ? len - 2 - idx : 3;     // targets stay at or before the end.
        case (kind)
            0:       pick = randomBelow(9);
            1:       pick = (randomBelow(2) == 1) ? 9 + randomBelow(2) : randomBelow(9);
            2:       pick = (randomBelow(2) == 1) ? 10 + randomBelow(4) : randomBelow(9);
            default: pick = randomBelow(14);
        endcase
        if (useLoad) begin
            pick = randomBelow(7);      // consume the load result right away.
            rs   = lastDst;
        end
        useLoad = 1'b0;
        case (pick)
            0:       funct = `FN_ADD;
            1:       funct = `FN_SUB;
            2:       funct = `FN_AND;
            3:       funct = `FN_OR;
            4:       funct = `FN_XOR;
            5:       funct = `FN_SLT;
            default: funct = `FN_SLL;
        endcase
        if (pick < 7) begin
            lastDst = rd;
            return {`OP_RTYPE, rs, rt, rd, 5'(randomWord() >> 27), funct};
        end
        if (pick < 10)
            lastDst = rt;
        case (pick)
            7:  return {`OP_ADDI, rs, rt, imm};
            8:  return {`OP_ORI, rs, rt, imm};
            9: begin
                useLoad = 1'b1;
                return {`OP_LW, 5'd0, rt, 16'(randomBelow(64) * 4)};
            end
            10: return {`OP_SW, 5'd0, rs, 16'(randomBelow(64) * 4)};
            11: return {`OP_BEQ, rs, (randomBelow(2) == 1) ? rs : rt, 16'(randomBelow(reach + 1))};
            12: return {`OP_BNE, rs, (randomBelow(2) == 1) ? rs : rt, 16'(randomBelow(reach + 1))};
            default: return {`OP_J, 10'd0, 16'(idx + 1 + randomBelow(reach + 1))};
        endcase
    endfunction

    task automatic buildProgram(input int kind, input int len);
        for (int i = 0; i < 256; i++)
            rom[8'(i)] = {`OP_J, 10'd0, 16'(i)};  // unused words jump to themselves.
        lastDst = 5'd1;
        useLoad = 1'b0;
        for (int i = 0; i < len - 1; i++)
            rom[8'(i)] = genInstr(kind, i, len);
        rom[8'(len - 1)] = {`OP_J, 10'd0, 16'(len - 1)};
        endPc = 16'((len - 1) * 4);
    endtask

    task automatic compareWord(
        input string                  name,
        input logic [`DATA_WIDTH-1:0] actual,
        input logic [`DATA_WIDTH-1:0] expected
    );
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic compareStore(
        input logic [`PC_WIDTH-1:0]   addr,
        input logic [`DATA_WIDTH-1:0] data,
        input logic [`PC_WIDTH-1:0]   expAddr,
        input logic [`DATA_WIDTH-1:0] expData
    );
        checkCount++;
        if (addr !== expAddr || data !== expData) begin
            errorCount++;
            $display("Fail MemAddr/WriteData got %h/%h expected %h/%h",
                     addr, data, expAddr, expData);
        end
    endtask

    task automatic compareAddr(
        input string                name,
        input logic [`PC_WIDTH-1:0] actual,
        input logic [`PC_WIDTH-1:0] expected
    );
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic compareFlag(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("Error: %s", what);
    endtask

    task automatic runProgram(input string name, input int kind, input int len);
        int errorsBefore;
        int stallsBefore;
        errorsBefore = errorCount;
        @(posedge Clock);
        #1;
        nReset = 1'b0;
        buildProgram(kind, len);
        runModel(len);
        storeBase    = storesSeen;
        stallsBefore = stallsSeen;
        repeat (resetCycles) @(posedge Clock);
        #1;
        nReset = 1'b1;
        @(negedge Clock);
        compareAddr("InstrAddr", InstrAddr, '0);
        compareFlag("MemWrite", MemWrite, 1'b0);
        compareFlag("MemRead", MemRead, 1'b0);
        compareFlag("nStall", nStall, 1'b1);
        while (InstrAddr != endPc)
            @(negedge Clock);
        repeat (10) @(negedge Clock);   // drain the pipeline.
        for (int r = 0; r < 32; r++) begin
            @(posedge Clock);
            #1;
            RegAddr = 5'(r);
            @(negedge Clock);
            compareWord($sformatf("RegData[%0d]", r), RegData, refRegs[5'(r)]);
        end
        if (storesSeen - storeBase != refStoreAddr.size())
            reportProblem($sformatf("core made %0d stores but the model made %0d",
                                    storesSeen - storeBase, refStoreAddr.size()));
        if (kind == 1 && stallsSeen == stallsBefore)
            reportProblem("memory program never stalled on a load-use hazard");
        testCount++;
        $display("%s: %0d errors", name, errorCount - errorsBefore);
    endtask

    // combinational ROM and registered-read data memory, both driven after the edge.
    initial begin : memoryModel
        logic                   doWrite;
        logic                   doRead;
        logic [`PC_WIDTH-1:0]   addr;
        logic [`DATA_WIDTH-1:0] data;
        int                     index;
        InstrMem = '0;
        MemData  = '0;
        forever begin
            @(negedge Clock);
            doWrite = MemWrite;
            doRead  = MemRead;
            addr    = MemAddr;
            data    = WriteData;
            if (!nStall)
                stallsSeen++;
            if (MemWrite) begin
                index = storesSeen - storeBase;
                if (index < refStoreAddr.size())
                    compareStore(MemAddr, WriteData, refStoreAddr[index], refStoreData[index]);
                else
                    reportProblem("core made a store past the end of the model's store list");
                storesSeen++;
            end
            @(posedge Clock);
            #1;
            if (!nReset) begin
                for (int i = 0; i < 64; i++)
                    dataMem[6'(i)] = fillWord(i);
            end
            if (doWrite)
                dataMem[addr[7:2]] = data;
            if (doRead)
                MemData = dataMem[addr[7:2]];
            InstrMem = rom[InstrAddr[9:2]];
        end
    end

    initial begin : watchdog
        while (cycles < cycleLimit) begin
            @(posedge Clock);
            cycles++;
        end
        $display("Run stopped: %0d cycles passed and the tests did not finish", cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        nReset   = 1'b0;
        RegAddr  = '0;
        lcgState = 32'he3bf;
        runProgram("alu program", 0, aluLength);
        runProgram("memory program", 1, memLength);
        runProgram("control program", 2, ctrlLength);
        runProgram("mixed program", 3, mixedLength);
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
+incdir+test
design/corePkg.sv
design/fetchStage.sv
design/registerFile.sv
design/decodeControl.sv
design/executeUnit.sv
design/memoryAccess.sv
design/pipelineCore.sv
test/coreTb.sv

//--- Makefile
# Verilator build and run of the pipelined core testbench.
# Any variable can be set on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= All checks passed

.PHONY: all build sim lint clean

all: sim

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# the log decides the result, not the simulator exit status.
sim: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
